// ==== rtl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // one word per line, 1024 sets
    localparam int index_w    = 10;           // address bits 11..2
    localparam int tag_w      = 20;           // address bits 31..12
    localparam int cache_sets = 1 << index_w;

    // cycles from memory accept to data_ok
    localparam int mem_latency = 3;

    // processor access size
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } size_e;

    // miss handling
    typedef enum logic [1:0] {
        st_ok   = 2'b00,  // ready, hits served here
        st_wb   = 2'b10,  // victim going back to memory
        st_fill = 2'b11   // waiting for the line from memory
    } state_e;

endpackage

`default_nettype wire

// ==== rtl/cache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_way (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [dcache_pkg::addr_w-1:0] addr,
    input  wire dcache_pkg::size_e             size,
    input  wire logic                          rep,
    input  wire logic                          we,
    input  wire logic                          wp,
    input  wire logic                          wm,
    input  wire logic                          wd,
    input  wire logic [dcache_pkg::data_w-1:0] data_w,
    output logic                               hit,
    output logic                               need_r,
    output logic      [dcache_pkg::tag_w-1:0]  ctag_r,
    output logic      [dcache_pkg::data_w-1:0] data_r
);
    import dcache_pkg::*;

    logic [cache_sets-1:0] valid;
    logic [cache_sets-1:0] dirty;
    logic [tag_w-1:0]      tag_mem  [cache_sets];
    logic [dcache_pkg::data_w-1:0] data_mem [cache_sets];

    logic [index_w-1:0] idx;
    logic [tag_w-1:0]   tag;
    logic [1:0]         off;

    assign idx = addr[index_w+1:2];
    assign tag = addr[addr_w-1:addr_w-tag_w];
    assign off = addr[1:0];

    // lookup, all combinational
    assign ctag_r = tag_mem[idx];
    assign data_r = data_mem[idx];
    assign hit    = valid[idx] & (ctag_r == tag);
    assign need_r = valid[idx] & dirty[idx];

    logic                          wr_en;
    logic [3:0]                    lanes;
    logic [dcache_pkg::data_w-1:0] wdata_sh;
    logic [dcache_pkg::data_w-1:0] merged;

    assign wr_en = we & (hit | rep);

    always_comb begin
        if (wm) begin
            lanes    = 4'b1111;  // whole word from memory
            wdata_sh = data_w;
        end else begin
            case (size)
                size_byte: lanes = 4'b0001 << off;
                size_half: lanes = 4'b0011 << off;
                default:   lanes = 4'b1111;
            endcase
            wdata_sh = data_w << {off, 3'b000};
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = lanes[b] ? wdata_sh[8*b +: 8] : data_r[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (wr_en && wp) begin
            valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[idx] <= merged;
            if (wp) begin
                tag_mem[idx] <= tag;
            end
            // wd wins, a plain fill leaves the line clean
            if (wd) begin
                dirty[idx] <= 1'b1;
            end else if (wp) begin
                dirty[idx] <= 1'b0;
            end
        end
    end

    // the controller only picks a victim when nothing hits
    a_rep_not_hit: assert property (@(posedge clk) disable iff (rst)
        we |-> !(hit && rep));

    // memory data always arrives with a new tag
    a_fill_tags: assert property (@(posedge clk) disable iff (rst)
        (we && wm) |-> wp);

endmodule

`default_nettype wire

// ==== rtl/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          sbus_update,
    input  wire logic                          sbus_en,
    input  wire logic                          sbus_we,
    input  wire dcache_pkg::size_e             sbus_size,
    input  wire logic [dcache_pkg::addr_w-1:0] sbus_addr,
    input  wire logic [dcache_pkg::data_w-1:0] sbus_data_w,
    output logic      [dcache_pkg::data_w-1:0] sbus_data_r,
    output logic                               sbus_stall,
    output logic                               sram_like_req,
    output logic                               sram_like_wr,
    output logic      [dcache_pkg::addr_w-1:0] sram_like_addr,
    output logic      [dcache_pkg::data_w-1:0] sram_like_wdata,
    input  wire logic [dcache_pkg::data_w-1:0] sram_like_rdata,
    input  wire logic                          sram_like_addr_ok,
    input  wire logic                          sram_like_data_ok
);
    import dcache_pkg::*;

    state_e state;

    logic [index_w-1:0] idx;
    logic [1:0]         off;

    assign idx = sbus_addr[index_w+1:2];
    assign off = sbus_addr[1:0];

    logic              we;
    logic              wp;
    logic              wm;
    logic              wd;
    logic              way_hit  [2];
    logic              way_rep  [2];
    logic              way_need [2];
    logic [tag_w-1:0]  way_ctag [2];
    logic [data_w-1:0] way_data [2];
    logic [data_w-1:0] fill_w;

    for (genvar i = 0; i < 2; i++) begin : g_way
        cache_way u_way (
            .clk    (clk),
            .rst    (rst),
            .addr   (sbus_addr),
            .size   (sbus_size),
            .rep    (way_rep[i]),
            .we     (we),
            .wp     (wp),
            .wm     (wm),
            .wd     (wd),
            .data_w (fill_w),
            .hit    (way_hit[i]),
            .need_r (way_need[i]),
            .ctag_r (way_ctag[i]),
            .data_r (way_data[i])
        );
    end

    logic hit;
    assign hit = way_hit[0] | way_hit[1];

    // lru bit names the way to replace next
    logic [cache_sets-1:0] lru_bits;
    logic                  lru;
    assign lru = lru_bits[idx];

    assign way_rep[0] = ~hit & ~lru;
    assign way_rep[1] = ~hit & lru;

    logic              dirty;
    logic [tag_w-1:0]  vtag;
    logic [data_w-1:0] vdata;

    assign dirty = way_need[lru];
    assign vtag  = way_ctag[lru];
    assign vdata = way_data[lru];

    logic full_word;
    logic need_wb;
    logic need_fill;
    logic in_ok;
    logic in_wb;
    logic in_fill;

    assign full_word = sbus_size == size_word;
    assign need_wb   = ~hit & dirty;
    assign need_fill = ~hit & (~sbus_we | ~full_word);  // partial writes fetch first
    assign in_ok     = state == st_ok;
    assign in_wb     = state == st_wb;
    assign in_fill   = state == st_fill;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_ok;
        end else begin
            case (state)
                st_ok: begin
                    if (sbus_en && need_wb) begin
                        state <= st_wb;
                    end else if (sbus_en && need_fill) begin
                        state <= st_fill;
                    end
                end
                st_wb: begin
                    if (sram_like_data_ok) begin
                        state <= need_fill ? st_fill : st_ok;
                    end
                end
                st_fill: begin
                    if (sram_like_data_ok) begin
                        state <= st_ok;
                    end
                end
                default: state <= st_ok;
            endcase
        end
    end

    logic we_fill;
    logic we_hit;
    logic we_alloc;

    assign we_fill  = in_fill & sram_like_data_ok;
    assign we_hit   = in_ok & sbus_en & sbus_we & hit;
    assign we_alloc = sbus_en & sbus_we & full_word & ~hit &
                      ((in_ok & ~dirty) | (in_wb & sram_like_data_ok));

    assign we     = we_fill | we_hit | we_alloc;
    assign wp     = we_fill | we_alloc;
    assign wm     = we_fill;
    assign wd     = we_hit | we_alloc;
    assign fill_w = wm ? sram_like_rdata : sbus_data_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_bits <= '0;
        end else if (wp) begin
            lru_bits[idx] <= ~lru;  // new line is most recent
        end else if (in_ok && sbus_en && hit) begin
            lru_bits[idx] <= way_hit[0];
        end
    end

    logic [data_w-1:0] word_sel;
    logic [data_w-1:0] shifted;
    logic [data_w-1:0] data_stored;
    logic              data_update;

    assign word_sel    = in_ok ? (way_hit[1] ? way_data[1] : way_data[0]) : sram_like_rdata;
    assign shifted     = word_sel >> {off, 3'b000};  // upper bytes zero-filled and unmasked
    assign data_update = (in_ok & sbus_en & ~sbus_we & hit) |
                         (in_fill & sram_like_data_ok & ~sbus_we);

    always_ff @(posedge clk) begin
        if (rst) begin
            data_stored <= '0;
        end else if (data_update) begin
            data_stored <= shifted;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sbus_data_r <= '0;
        end else if (sbus_update) begin
            sbus_data_r <= data_update ? shifted : data_stored;
        end
    end

    // a partial write stalls through the fill and merges on the next hit
    assign sbus_stall = (in_ok & sbus_en & (need_wb | need_fill)) |
                        (in_wb & ~(sram_like_data_ok & ~need_fill)) |
                        (in_fill & (~sram_like_data_ok | sbus_we));

    logic start;
    logic req_q;

    assign start = (in_ok & sbus_en & (need_wb | need_fill)) |
                   (in_wb & sram_like_data_ok & need_fill);

    always_ff @(posedge clk) begin
        if (rst || sram_like_addr_ok) begin
            req_q <= 1'b0;
        end else if (start) begin
            req_q <= 1'b1;  // held until accepted
        end
    end

    assign sram_like_req   = start | req_q;
    assign sram_like_wr    = (in_ok & need_wb) | (in_wb & req_q);
    assign sram_like_addr  = sram_like_wr ? {vtag, idx, 2'b00} : {sbus_addr[addr_w-1:2], 2'b00};
    assign sram_like_wdata = vdata;

    // accepted memory transaction still owed a data_ok
    logic mem_pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_pending <= 1'b0;
        end else if (sram_like_req && sram_like_addr_ok) begin
            mem_pending <= 1'b1;
        end else if (sram_like_data_ok) begin
            mem_pending <= 1'b0;
        end
    end

    a_one_hit: assert property (@(posedge clk) disable iff (rst)
        !(way_hit[0] && way_hit[1]));

    a_req_en: assert property (@(posedge clk) disable iff (rst)
        (in_ok && sram_like_req) |-> sbus_en);

    // no state change while memory owes an answer
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_pending && !sram_like_data_ok) |=> $stable(state));

endmodule

`default_nettype wire

// ==== rtl/sram_like_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_like_mem #(
    parameter int words_log2 = 12
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          req,
    input  wire logic                          wr,
    input  wire logic [dcache_pkg::addr_w-1:0] addr,
    input  wire logic [dcache_pkg::data_w-1:0] wdata,
    output logic      [dcache_pkg::data_w-1:0] rdata,
    output logic                               addr_ok,
    output logic                               data_ok
);
    import dcache_pkg::*;

    logic [data_w-1:0] mem [2**words_log2];

    logic                  busy;
    int                    cnt;
    logic                  wr_q;
    logic [words_log2-1:0] addr_q;
    logic [data_w-1:0]     wdata_q;

    // word i holds ~i over i
    initial begin
        for (int i = 0; i < 2**words_log2; i++) begin
            mem[i] = {~i[15:0], i[15:0]};
        end
    end

    assign data_ok = busy & (cnt == mem_latency);
    assign addr_ok = req & (~busy | data_ok);  // back-to-back accept allowed
    assign rdata   = mem[addr_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= 0;
        end else if (addr_ok) begin
            busy <= 1'b1;
            cnt  <= 1;
        end else if (data_ok) begin
            busy <= 1'b0;
        end else if (busy) begin
            cnt <= cnt + 1;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            wr_q    <= wr;
            addr_q  <= addr[words_log2+1:2];  // wraps modulo size
            wdata_q <= wdata;
        end
    end

    // write lands at completion
    always @(posedge clk) begin
        if (data_ok && wr_q) begin
            mem[addr_q] <= wdata_q;
        end
    end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        data_ok |-> $past(addr_ok, mem_latency));

endmodule

`default_nettype wire

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          sbus_update,
    input  wire logic                          sbus_en,
    input  wire logic                          sbus_we,
    input  wire dcache_pkg::size_e             sbus_size,
    input  wire logic [dcache_pkg::addr_w-1:0] sbus_addr,
    input  wire logic [dcache_pkg::data_w-1:0] sbus_data_w,
    output logic      [dcache_pkg::data_w-1:0] sbus_data_r,
    output logic                               sbus_stall
);
    import dcache_pkg::*;

    // memory side
    logic              sram_like_req;
    logic              sram_like_wr;
    logic [addr_w-1:0] sram_like_addr;
    logic [data_w-1:0] sram_like_wdata;
    logic [data_w-1:0] sram_like_rdata;
    logic              sram_like_addr_ok;
    logic              sram_like_data_ok;

    dcache u_dcache (
        .clk               (clk),
        .rst               (rst),
        .sbus_update       (sbus_update),
        .sbus_en           (sbus_en),
        .sbus_we           (sbus_we),
        .sbus_size         (sbus_size),
        .sbus_addr         (sbus_addr),
        .sbus_data_w       (sbus_data_w),
        .sbus_data_r       (sbus_data_r),
        .sbus_stall        (sbus_stall),
        .sram_like_req     (sram_like_req),
        .sram_like_wr      (sram_like_wr),
        .sram_like_addr    (sram_like_addr),
        .sram_like_wdata   (sram_like_wdata),
        .sram_like_rdata   (sram_like_rdata),
        .sram_like_addr_ok (sram_like_addr_ok),
        .sram_like_data_ok (sram_like_data_ok)
    );

    sram_like_mem u_mem (
        .clk     (clk),
        .rst     (rst),
        .req     (sram_like_req),
        .wr      (sram_like_wr),
        .addr    (sram_like_addr),
        .wdata   (sram_like_wdata),
        .rdata   (sram_like_rdata),
        .addr_ok (sram_like_addr_ok),
        .data_ok (sram_like_data_ok)
    );

endmodule

`default_nettype wire

// ==== test/dcache_vectors.svh ====
`ifndef dcache_vectors_svh
`define dcache_vectors_svh

// columns: we, size, address, write data, stall expected
localparam int num_vectors = 37;

vec_t vectors [num_vectors] = '{
    // cold read, then hits on the same word
    '{1'b0, size_word, 32'h0000_0100, 32'h0000_0000, 1'b1},
    '{1'b0, size_word, 32'h0000_0100, 32'h0000_0000, 1'b0},
    '{1'b0, size_byte, 32'h0000_0103, 32'h0000_0000, 1'b0},
    '{1'b0, size_half, 32'h0000_0102, 32'h0000_0000, 1'b0},
    // byte write miss fetches first
    '{1'b1, size_byte, 32'h0000_0105, 32'h0000_00a5, 1'b1},
    '{1'b0, size_word, 32'h0000_0104, 32'h0000_0000, 1'b0},
    '{1'b1, size_half, 32'h0000_0106, 32'h0000_1234, 1'b0},
    '{1'b0, size_byte, 32'h0000_0104, 32'h0000_0000, 1'b0},
    '{1'b0, size_byte, 32'h0000_0105, 32'h0000_0000, 1'b0},
    '{1'b0, size_byte, 32'h0000_0106, 32'h0000_0000, 1'b0},
    '{1'b0, size_byte, 32'h0000_0107, 32'h0000_0000, 1'b0},
    '{1'b1, size_word, 32'h0000_0108, 32'hdead_beef, 1'b0},  // allocates, no fetch
    '{1'b0, size_word, 32'h0000_0108, 32'h0000_0000, 1'b0},
    '{1'b0, size_half, 32'h0000_010a, 32'h0000_0000, 1'b0},
    '{1'b1, size_byte, 32'h0000_0108, 32'h0000_0077, 1'b0},
    '{1'b0, size_word, 32'h0000_0108, 32'h0000_0000, 1'b0},
    // set 0x50, dirty lines pushed out and read back
    '{1'b1, size_word, 32'h0000_0140, 32'hcafe_0001, 1'b0},
    '{1'b0, size_word, 32'h0000_1140, 32'h0000_0000, 1'b1},
    '{1'b0, size_word, 32'h0000_2140, 32'h0000_0000, 1'b1},  // evicts the dirty line
    '{1'b0, size_word, 32'h0000_0140, 32'h0000_0000, 1'b1},
    '{1'b1, size_word, 32'h0000_3140, 32'h600d_f00d, 1'b0},
    '{1'b1, size_word, 32'h0000_1140, 32'h0b0b_0b0b, 1'b0},
    '{1'b1, size_word, 32'h0000_0140, 32'h0a0a_0a0a, 1'b1},  // write back, then allocate
    '{1'b0, size_word, 32'h0000_3140, 32'h0000_0000, 1'b1},
    '{1'b0, size_word, 32'h0000_1140, 32'h0000_0000, 1'b1},
    '{1'b0, size_word, 32'h0000_0140, 32'h0000_0000, 1'b1},
    // lru order in set 0x60
    '{1'b0, size_word, 32'h0000_0180, 32'h0000_0000, 1'b1},
    '{1'b0, size_word, 32'h0000_1180, 32'h0000_0000, 1'b1},
    '{1'b0, size_word, 32'h0000_0180, 32'h0000_0000, 1'b0},
    '{1'b0, size_word, 32'h0000_2180, 32'h0000_0000, 1'b1},
    '{1'b0, size_word, 32'h0000_0180, 32'h0000_0000, 1'b0},
    '{1'b0, size_word, 32'h0000_1180, 32'h0000_0000, 1'b1},
    // half write miss over a dirty victim
    '{1'b1, size_word, 32'h0000_01c0, 32'h1111_1111, 1'b0},
    '{1'b1, size_word, 32'h0000_11c0, 32'h2222_2222, 1'b0},
    '{1'b1, size_half, 32'h0000_21c2, 32'h0000_beef, 1'b1},
    '{1'b0, size_word, 32'h0000_21c0, 32'h0000_0000, 1'b0},
    '{1'b0, size_word, 32'h0000_01c0, 32'h0000_0000, 1'b1}
};

`endif

// ==== test/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 4;
    localparam int random_ops   = 200;
    localparam int mem_bytes    = 4 << 12;  // default memory depth, 16 KiB
    localparam int op_cycles    = 2 * (mem_latency + 2) + 2;

    typedef struct packed {
        logic        we;
        size_e       size;
        logic [31:0] addr;
        logic [31:0] data;
        logic        stall;
    } vec_t;

    `include "dcache_vectors.svh"

    localparam int total_ops = num_vectors + random_ops + 4;

    logic        clk;
    logic        rst;
    logic        sbus_update;
    logic        sbus_en;
    logic        sbus_we;
    size_e       sbus_size;
    logic [31:0] sbus_addr;
    logic [31:0] sbus_data_w;
    logic [31:0] sbus_data_r;
    logic        sbus_stall;

    logic [7:0] model_mem [mem_bytes];  // byte image of main memory
    int         mismatches;
    int         failures;
    int         reads_checked;

    dcache_top UUT (
        .clk         (clk),
        .rst         (rst),
        .sbus_update (sbus_update),
        .sbus_en     (sbus_en),
        .sbus_we     (sbus_we),
        .sbus_size   (sbus_size),
        .sbus_addr   (sbus_addr),
        .sbus_data_w (sbus_data_w),
        .sbus_data_r (sbus_data_r),
        .sbus_stall  (sbus_stall)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic load_initial_content();
        logic [15:0] low;
        for (int i = 0; i < mem_bytes / 4; i++) begin
            low = i[15:0];
            {model_mem[4*i+3], model_mem[4*i+2], model_mem[4*i+1], model_mem[4*i]} = {~low, low};
        end
    endtask

    // word shifted down by the offset, zeros from above
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        int          base;
        int          off;
        logic [31:0] word;
        base = int'(addr[13:2]) * 4;
        off  = int'(addr[1:0]);
        word = '0;
        for (int b = off; b < 4; b++) begin
            word[8*(b-off) +: 8] = model_mem[base + b];
        end
        return word;
    endfunction

    task automatic store_bytes(input logic [31:0] addr, input size_e size,
                               input logic [31:0] data);
        int base;
        int n;
        base = int'(addr[13:0]);
        n    = (size == size_byte) ? 1 : (size == size_half) ? 2 : 4;
        for (int b = 0; b < n; b++) begin
            model_mem[base + b] = data[8*b +: 8];
        end
    endtask

    // entered and left on a falling edge
    task automatic access(input logic we, input size_e size, input logic [31:0] addr,
                          input logic [31:0] data, input logic update, output logic stalled);
        logic [31:0] expected;
        expected    = expected_word(addr);
        stalled     = 1'b0;
        sbus_en     = 1'b1;
        sbus_we     = we;
        sbus_size   = size;
        sbus_addr   = addr;
        sbus_data_w = data;
        sbus_update = update;
        #10;
        while (sbus_stall) begin
            stalled = 1'b1;
            @(negedge clk);
            #10;
        end
        @(negedge clk);  // completed at the rising edge just passed
        sbus_en = 1'b0;
        sbus_we = 1'b0;
        if (we) begin
            store_bytes(addr, size, data);
        end else if (update) begin
            reads_checked++;
            assert (sbus_data_r == expected) else begin
                mismatches++;
                $display("mismatch at %0t: read of %h returned %h, expected %h",
                         $time, addr, sbus_data_r, expected);
            end
        end
    endtask

    task automatic run_vectors();
        logic stalled;
        for (int i = 0; i < num_vectors; i++) begin
            access(vectors[i].we, vectors[i].size, vectors[i].addr, vectors[i].data,
                   1'b1, stalled);
            assert (stalled == vectors[i].stall) else begin
                failures++;
                if (vectors[i].stall) begin
                    $display("vector %0d at %0t: access to %h should have stalled but did not",
                             i, $time, vectors[i].addr);
                end else begin
                    $display("vector %0d at %0t: access to %h stalled on what should be a hit",
                             i, $time, vectors[i].addr);
                end
            end
        end
    endtask

    task automatic check_update_strobe();
        logic        stalled;
        logic [31:0] held;
        logic [31:0] fresh;
        held  = expected_word(32'h0000_0240);
        fresh = expected_word(32'h0000_0285);
        access(1'b0, size_word, 32'h0000_0240, 32'h0, 1'b1, stalled);
        access(1'b0, size_byte, 32'h0000_0285, 32'h0, 1'b0, stalled);
        assert (sbus_data_r == held) else begin
            mismatches++;
            $display("mismatch at %0t: read data moved with update low, got %h, expected %h",
                     $time, sbus_data_r, held);
        end
        sbus_update = 1'b1;  // idle cycle, no access
        @(negedge clk);
        assert (sbus_data_r == fresh) else begin
            mismatches++;
            $display("mismatch at %0t: late update gave %h, expected %h",
                     $time, sbus_data_r, fresh);
        end
    endtask

    // four tags in bits 13..12 over sets 0x200..0x207
    task automatic random_traffic();
        logic        stalled;
        logic [31:0] r;
        logic [31:0] data;
        logic [1:0]  off;
        size_e       size;
        for (int n = 0; n < random_ops; n++) begin
            r = $urandom();
            case (r[11:10])
                2'd0:    size = size_byte;
                2'd1:    size = size_half;
                default: size = size_word;
            endcase
            off = r[3:2];
            if (size == size_half) begin
                off[0] = 1'b0;
            end else if (size == size_word) begin
                off = 2'b00;
            end
            data = $urandom();
            access(r[9], size, {18'b0, r[5:4], 7'b100_0000, r[8:6], off}, data, 1'b1, stalled);
        end
    endtask

    initial begin
        mismatches    = 0;
        failures      = 0;
        reads_checked = 0;
        rst           = 1'b1;
        sbus_update   = 1'b1;
        sbus_en       = 1'b0;
        sbus_we       = 1'b0;
        sbus_size     = size_word;
        sbus_addr     = '0;
        sbus_data_w   = '0;
        void'($urandom(32'h0bba8500));
        load_initial_content();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        assert (!sbus_stall && sbus_data_r == '0) else begin
            failures++;
            $display("after reset the cache stalls or shows nonzero read data");
        end
        rst = 1'b0;
        run_vectors();
        check_update_strobe();
        random_traffic();
        $display("reads checked %0d, mismatches %0d, other errors %0d",
                 reads_checked, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (reset_cycles + total_ops * op_cycles) @(posedge clk);
        $display("timeout: the run did not finish within the bound for %0d accesses", total_ops);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache.f ====
+incdir+test
rtl/dcache_pkg.sv
rtl/cache_way.sv
rtl/dcache.sv
rtl/sram_like_mem.sv
rtl/dcache_top.sv
test/tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the dcache testbench with Verilator, run it, report the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_dcache -f dcache.f \
    || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/Vtb_dcache)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qF '** PASS **' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
